//--- common/dvs_pkg.sv
/* Shared widths, word type codes, FSM states and register map of the DVS readout.
   Encoded word is {type[3:0], t_low[5:0], x[10:0], y[10:0]} or {TIME_HIGH, t_high[27:0]}. */
package dvs_pkg;

  localparam int ROW_ADD     = 11;                  // Row (x) address width
  localparam int COL_ADD     = 11;                  // Column (y) address width
  localparam int SIZE        = 34;                  // Timestamp width
  localparam int TIME_LOW_W  = 6;                   // Low field carried in CD words
  localparam int TIME_HIGH_W = 28;                  // High field carried in TIME_HIGH words
  localparam int WIDTH       = 32;                  // Encoded word and AXI data width
  localparam int FIFO_DEPTH  = 16;                  // Word FIFO entries
  localparam int FIFO_CNT_W  = 5;                   // Fill count, 0 to FIFO_DEPTH
  localparam int PRESCALE_W  = 16;                  // Tick divider width

  localparam logic [1:0] RESP_OKAY   = 2'b00;       // AXI OKAY
  localparam logic [1:0] RESP_SLVERR = 2'b10;       // AXI SLVERR

  typedef enum logic [3:0] {
    TYPE_CD_OFF    = 4'b0000,                       // Brightness decrease
    TYPE_CD_ON     = 4'b0001,                       // Brightness increase
    TYPE_TIME_HIGH = 4'b1000                        // Upper timestamp bits
  } word_type_e;

  typedef enum logic [1:0] {
    ENC_IDLE,                                       // Waiting for an event
    ENC_TIME_HIGH,                                  // Writing the TIME_HIGH word
    ENC_CD                                          // Writing the CD word
  } enc_state_e;

  typedef enum logic [3:0] {
    REG_CTRL     = 4'h0,                            // bit0 enable, bit1 timestamp clear
    REG_STATUS   = 4'h4,                            // FIFO fill count
    REG_DATA     = 4'h8,                            // Read pops one FIFO word
    REG_PRESCALE = 4'hC                             // Tick divider
  } reg_addr_e;

endpackage

//--- hdl/aer_capture.sv
/* Four-phase AER receiver. The sensor must hold x, y and pol stable while req is high.
   A new event is only acknowledged once the previous one has been taken downstream. */
module aer_capture
  (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        enable_i,
  input  logic                        aer_req_i,    // Asynchronous sensor request
  input  logic [dvs_pkg::ROW_ADD-1:0] aer_x_i,
  input  logic [dvs_pkg::COL_ADD-1:0] aer_y_i,
  input  logic                        aer_pol_i,
  output logic                        aer_ack_o,
  output logic                        evt_valid_o,
  output logic [dvs_pkg::ROW_ADD-1:0] evt_x_o,
  output logic [dvs_pkg::COL_ADD-1:0] evt_y_o,
  output logic                        evt_pol_o,
  input  logic                        evt_ready_i
  );

  logic req_s1;                                     // First synchronizer stage
  logic req_s2;                                     // Second stage, safe to use
  logic ack_q;                                      // Handshake in progress
  logic latch;

  // Latch on synchronized req while idle, enabled and with the output slot free
  assign latch = req_s2 && !ack_q && !evt_valid_o && enable_i;

  // Gating with req_s2 drops ack one cycle before ack_q clears
  assign aer_ack_o = ack_q && req_s2;

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      req_s1      <= 1'b0;
      req_s2      <= 1'b0;
      ack_q       <= 1'b0;
      evt_valid_o <= 1'b0;
    end
    else
    begin
      req_s1 <= aer_req_i;
      req_s2 <= req_s1;
      if (latch)
        ack_q <= 1'b1;                              // Event latched, acknowledge
      else if (!req_s2)
        ack_q <= 1'b0;                              // Sensor released req
      if (latch)
        evt_valid_o <= 1'b1;
      else if (evt_ready_i)
        evt_valid_o <= 1'b0;                        // Taken by the encoder
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (latch)
    begin
      evt_x_o   <= aer_x_i;                         // Address stable under req
      evt_y_o   <= aer_y_i;
      evt_pol_o <= aer_pol_i;
    end
  end

endmodule

//--- hdl/timestamp_counter.sv
/* Timestamp advances once every prescale_i+1 cycles; prescale 0 ticks every cycle.
   clear_i zeroes divider and timestamp. The 34-bit count wraps silently. */
module timestamp_counter
  (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           clear_i,
  input  logic [dvs_pkg::PRESCALE_W-1:0] prescale_i,
  output logic [dvs_pkg::SIZE-1:0]       timestamp_o
  );

  logic [dvs_pkg::PRESCALE_W-1:0] div_q;           // Cycles since the last tick

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      div_q       <= '0;
      timestamp_o <= '0;
    end
    else if (clear_i)
    begin
      div_q       <= '0;
      timestamp_o <= '0;
    end
    else if (div_q >= prescale_i)                   // Also catches a lowered prescale
    begin
      div_q       <= '0;
      timestamp_o <= timestamp_o + 1'b1;
    end
    else
      div_q <= div_q + 1'b1;
  end

endmodule

//--- encoder/event_encoder.sv
/* Takes one event at a time and writes a TIME_HIGH word first when the high field has
   changed or none was sent since enable. Stalls in place while the FIFO is full. */
module event_encoder
  (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        enable_i,
  input  logic                        evt_valid_i,
  input  logic [dvs_pkg::ROW_ADD-1:0] evt_x_i,
  input  logic [dvs_pkg::COL_ADD-1:0] evt_y_i,
  input  logic                        evt_pol_i,
  output logic                        evt_ready_o,
  input  logic [dvs_pkg::SIZE-1:0]    timestamp_i,
  output logic                        wr_en_o,
  output logic [dvs_pkg::WIDTH-1:0]   wr_data_o,
  input  logic                        full_i
  );

  dvs_pkg::enc_state_e state_q;
  logic [dvs_pkg::ROW_ADD-1:0]     x_q;
  logic [dvs_pkg::COL_ADD-1:0]     y_q;
  logic                            pol_q;
  logic [dvs_pkg::SIZE-1:0]        ts_q;            // Timestamp sampled on acceptance
  logic [dvs_pkg::TIME_HIGH_W-1:0] last_high_q;    // High field last written
  logic                            high_sent_q;    // last_high_q is meaningful
  logic [dvs_pkg::TIME_HIGH_W-1:0] ts_high;
  logic                            accept;
  logic                            high_due;

  assign ts_high     = timestamp_i[dvs_pkg::SIZE-1:dvs_pkg::TIME_LOW_W];
  assign evt_ready_o = enable_i && (state_q == dvs_pkg::ENC_IDLE) && !full_i;
  assign accept      = evt_valid_i && evt_ready_o;
  assign high_due    = !high_sent_q || (ts_high != last_high_q);
  assign wr_en_o     = enable_i && (state_q != dvs_pkg::ENC_IDLE) && !full_i;

  always_comb
  begin
    if (state_q == dvs_pkg::ENC_TIME_HIGH)
      wr_data_o = {dvs_pkg::TYPE_TIME_HIGH, ts_q[dvs_pkg::SIZE-1:dvs_pkg::TIME_LOW_W]};
    else
      wr_data_o = {pol_q ? dvs_pkg::TYPE_CD_ON : dvs_pkg::TYPE_CD_OFF,
                   ts_q[dvs_pkg::TIME_LOW_W-1:0], x_q, y_q};
  end

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      state_q     <= dvs_pkg::ENC_IDLE;
      high_sent_q <= 1'b0;
    end
    else if (!enable_i)
    begin
      state_q     <= dvs_pkg::ENC_IDLE;             // Forget the high field
      high_sent_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        dvs_pkg::ENC_IDLE:
          if (accept)
            state_q <= high_due ? dvs_pkg::ENC_TIME_HIGH : dvs_pkg::ENC_CD;
        dvs_pkg::ENC_TIME_HIGH:
          if (!full_i)
          begin
            state_q     <= dvs_pkg::ENC_CD;
            high_sent_q <= 1'b1;
          end
        dvs_pkg::ENC_CD:
          if (!full_i)
            state_q <= dvs_pkg::ENC_IDLE;           // Ready for the next event
        default:
          state_q <= dvs_pkg::ENC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      x_q   <= evt_x_i;
      y_q   <= evt_y_i;
      pol_q <= evt_pol_i;
      ts_q  <= timestamp_i;
    end
    if (wr_en_o && (state_q == dvs_pkg::ENC_TIME_HIGH))
      last_high_q <= ts_q[dvs_pkg::SIZE-1:dvs_pkg::TIME_LOW_W];
  end

endmodule

//--- hdl/event_fifo.sv
/* Circular word buffer with the head word shown on rd_data_o. Writes when full and
   reads when empty are ignored; a read and a write may share a cycle. */
module event_fifo
  (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           wr_en_i,
  input  logic [dvs_pkg::WIDTH-1:0]      wr_data_i,
  input  logic                           rd_en_i,
  output logic [dvs_pkg::WIDTH-1:0]      rd_data_o,
  output logic                           full_o,
  output logic                           empty_o,
  output logic [dvs_pkg::FIFO_CNT_W-1:0] count_o
  );

  logic [dvs_pkg::WIDTH-1:0]      mem [dvs_pkg::FIFO_DEPTH];
  logic [dvs_pkg::FIFO_CNT_W-2:0] wr_ptr_q;        // Wraps at FIFO_DEPTH
  logic [dvs_pkg::FIFO_CNT_W-2:0] rd_ptr_q;
  logic                           push;
  logic                           pop;

  assign full_o    = (count_o == dvs_pkg::FIFO_CNT_W'(dvs_pkg::FIFO_DEPTH));
  assign empty_o   = (count_o == '0);
  assign push      = wr_en_i && !full_o;
  assign pop       = rd_en_i && !empty_o;
  assign rd_data_o = mem[rd_ptr_q];                 // First-word view

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop)
        count_o <= count_o + 1'b1;
      else if (pop && !push)
        count_o <= count_o - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem[wr_ptr_q] <= wr_data_i;
  end

endmodule

//--- hdl/axi_lite_regs.sv
/* AXI4-Lite slave, one transaction at a time per direction, full-word writes only.
   A DATA read pops only when a word is returned; on an empty FIFO it gives SLVERR. */
module axi_lite_regs
  (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic [3:0]                     s_awaddr_i,
  input  logic                           s_awvalid_i,
  output logic                           s_awready_o,
  input  logic [dvs_pkg::WIDTH-1:0]      s_wdata_i,
  input  logic                           s_wvalid_i,
  output logic                           s_wready_o,
  output logic [1:0]                     s_bresp_o,
  output logic                           s_bvalid_o,
  input  logic                           s_bready_i,
  input  logic [3:0]                     s_araddr_i,
  input  logic                           s_arvalid_i,
  output logic                           s_arready_o,
  output logic [dvs_pkg::WIDTH-1:0]      s_rdata_o,
  output logic [1:0]                     s_rresp_o,
  output logic                           s_rvalid_o,
  input  logic                           s_rready_i,
  output logic                           enable_o,
  output logic                           ts_clear_o,      // One-cycle pulse
  output logic [dvs_pkg::PRESCALE_W-1:0] prescale_o,
  output logic                           fifo_rd_en_o,
  input  logic [dvs_pkg::WIDTH-1:0]      fifo_rd_data_i,
  input  logic                           fifo_empty_i,
  input  logic [dvs_pkg::FIFO_CNT_W-1:0] fifo_count_i
  );

  dvs_pkg::reg_addr_e        wr_addr;
  dvs_pkg::reg_addr_e        rd_addr;
  logic                      aw_hs;
  logic                      ar_hs;
  logic [dvs_pkg::WIDTH-1:0] rd_word;
  logic [1:0]                rd_resp;

  assign wr_addr      = dvs_pkg::reg_addr_e'(s_awaddr_i);
  assign rd_addr      = dvs_pkg::reg_addr_e'(s_araddr_i);
  assign s_wready_o   = s_awready_o;                      // Address and data taken together
  assign aw_hs        = s_awready_o && s_awvalid_i && s_wvalid_i;
  assign ar_hs        = s_arready_o && s_arvalid_i;
  assign s_bresp_o    = dvs_pkg::RESP_OKAY;
  assign fifo_rd_en_o = ar_hs && (rd_addr == dvs_pkg::REG_DATA) && !fifo_empty_i;

  always_comb
  begin
    rd_word = '0;
    rd_resp = dvs_pkg::RESP_OKAY;
    case (rd_addr)
      dvs_pkg::REG_CTRL:
        rd_word = {{(dvs_pkg::WIDTH-1){1'b0}}, enable_o};  // Clear bit reads back 0
      dvs_pkg::REG_STATUS:
        rd_word = {{(dvs_pkg::WIDTH-dvs_pkg::FIFO_CNT_W){1'b0}}, fifo_count_i};
      dvs_pkg::REG_DATA:
        if (fifo_empty_i)
          rd_resp = dvs_pkg::RESP_SLVERR;                 // Nothing to pop
        else
          rd_word = fifo_rd_data_i;
      dvs_pkg::REG_PRESCALE:
        rd_word = {{(dvs_pkg::WIDTH-dvs_pkg::PRESCALE_W){1'b0}}, prescale_o};
      default:
        rd_word = '0;                                     // Unmapped offset
    endcase
  end

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      s_awready_o <= 1'b0;
      s_bvalid_o  <= 1'b0;
      s_arready_o <= 1'b0;
      s_rvalid_o  <= 1'b0;
      enable_o    <= 1'b0;
      ts_clear_o  <= 1'b0;
      prescale_o  <= '0;
    end
    else
    begin
      ts_clear_o  <= 1'b0;
      s_awready_o <= !s_awready_o && !s_bvalid_o && s_awvalid_i && s_wvalid_i;
      s_arready_o <= !s_arready_o && !s_rvalid_o && s_arvalid_i;
      if (aw_hs)
      begin
        s_bvalid_o <= 1'b1;
        case (wr_addr)
          dvs_pkg::REG_CTRL:
          begin
            enable_o   <= s_wdata_i[0];
            ts_clear_o <= s_wdata_i[1];
          end
          dvs_pkg::REG_PRESCALE:
            prescale_o <= s_wdata_i[dvs_pkg::PRESCALE_W-1:0];
          default:
            prescale_o <= prescale_o;                     // Read-only or unmapped
        endcase
      end
      else if (s_bready_i)
        s_bvalid_o <= 1'b0;
      if (ar_hs)
        s_rvalid_o <= 1'b1;
      else if (s_rready_i)
        s_rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (ar_hs)
    begin
      s_rdata_o <= rd_word;                               // Held until rready
      s_rresp_o <= rd_resp;
    end
  end

endmodule

//--- hdl/dvs_readout_top.sv
/* DVS readout path: AER capture, timestamp, event encoder, word FIFO and AXI4-Lite
   register slave. A full FIFO back-pressures the sensor by withholding ack. */
module dvs_readout_top
  (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        aer_req_i,
  input  logic [dvs_pkg::ROW_ADD-1:0] aer_x_i,
  input  logic [dvs_pkg::COL_ADD-1:0] aer_y_i,
  input  logic                        aer_pol_i,
  output logic                        aer_ack_o,
  input  logic [3:0]                  s_awaddr_i,
  input  logic                        s_awvalid_i,
  output logic                        s_awready_o,
  input  logic [dvs_pkg::WIDTH-1:0]   s_wdata_i,
  input  logic                        s_wvalid_i,
  output logic                        s_wready_o,
  output logic [1:0]                  s_bresp_o,
  output logic                        s_bvalid_o,
  input  logic                        s_bready_i,
  input  logic [3:0]                  s_araddr_i,
  input  logic                        s_arvalid_i,
  output logic                        s_arready_o,
  output logic [dvs_pkg::WIDTH-1:0]   s_rdata_o,
  output logic [1:0]                  s_rresp_o,
  output logic                        s_rvalid_o,
  input  logic                        s_rready_i
  );

  logic                           evt_valid;        // Capture to encoder
  logic [dvs_pkg::ROW_ADD-1:0]    evt_x;
  logic [dvs_pkg::COL_ADD-1:0]    evt_y;
  logic                           evt_pol;
  logic                           evt_ready;
  logic [dvs_pkg::SIZE-1:0]       timestamp;
  logic                           wr_en;            // Encoder to FIFO
  logic [dvs_pkg::WIDTH-1:0]      wr_data;
  logic                           full;
  logic                           rd_en;            // FIFO to register slave
  logic [dvs_pkg::WIDTH-1:0]      rd_data;
  logic                           empty;
  logic [dvs_pkg::FIFO_CNT_W-1:0] count;
  logic                           enable;           // Control from the register slave
  logic                           ts_clear;
  logic [dvs_pkg::PRESCALE_W-1:0] prescale;

  aer_capture u_capture (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .enable_i    (enable),
    .aer_req_i   (aer_req_i),
    .aer_x_i     (aer_x_i),
    .aer_y_i     (aer_y_i),
    .aer_pol_i   (aer_pol_i),
    .aer_ack_o   (aer_ack_o),
    .evt_valid_o (evt_valid),
    .evt_x_o     (evt_x),
    .evt_y_o     (evt_y),
    .evt_pol_o   (evt_pol),
    .evt_ready_i (evt_ready)
  );

  timestamp_counter u_timestamp (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .clear_i     (ts_clear),
    .prescale_i  (prescale),
    .timestamp_o (timestamp)
  );

  event_encoder u_encoder (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .enable_i    (enable),
    .evt_valid_i (evt_valid),
    .evt_x_i     (evt_x),
    .evt_y_i     (evt_y),
    .evt_pol_i   (evt_pol),
    .evt_ready_o (evt_ready),
    .timestamp_i (timestamp),
    .wr_en_o     (wr_en),
    .wr_data_o   (wr_data),
    .full_i      (full)
  );

  event_fifo u_fifo (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wr_en_i   (wr_en),
    .wr_data_i (wr_data),
    .rd_en_i   (rd_en),
    .rd_data_o (rd_data),
    .full_o    (full),
    .empty_o   (empty),
    .count_o   (count)
  );

  axi_lite_regs u_regs (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .s_awaddr_i     (s_awaddr_i),
    .s_awvalid_i    (s_awvalid_i),
    .s_awready_o    (s_awready_o),
    .s_wdata_i      (s_wdata_i),
    .s_wvalid_i     (s_wvalid_i),
    .s_wready_o     (s_wready_o),
    .s_bresp_o      (s_bresp_o),
    .s_bvalid_o     (s_bvalid_o),
    .s_bready_i     (s_bready_i),
    .s_araddr_i     (s_araddr_i),
    .s_arvalid_i    (s_arvalid_i),
    .s_arready_o    (s_arready_o),
    .s_rdata_o      (s_rdata_o),
    .s_rresp_o      (s_rresp_o),
    .s_rvalid_o     (s_rvalid_o),
    .s_rready_i     (s_rready_i),
    .enable_o       (enable),
    .ts_clear_o     (ts_clear),
    .prescale_o     (prescale),
    .fifo_rd_en_o   (rd_en),
    .fifo_rd_data_i (rd_data),
    .fifo_empty_i   (empty),
    .fifo_count_i   (count)
  );

endmodule

//--- testbench/dvs_readout_props.sv
/* Concurrent checks bound into every dvs_readout_top instance.
   The simulator must run with assertions enabled. */
module dvs_readout_props
  (
  input logic                           clk_i,
  input logic                           reset_i,
  input logic                           aer_req_i,
  input logic                           aer_ack_i,
  input logic                           wr_en_i,         // Encoder write strobe
  input logic                           rd_en_i,         // Host pop strobe
  input logic [dvs_pkg::FIFO_CNT_W-1:0] count_i,         // FIFO fill count
  input logic                           bvalid_i,
  input logic                           bready_i,
  input logic                           rvalid_i,
  input logic                           rready_i
  );

  // Ack only answers a pending request
  ack_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(aer_ack_i) |-> aer_req_i)
    else $error("aer_ack_o rose without aer_req_i");

  // A write into a full FIFO would leave the count unchanged
  write_is_stored: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_en_i && !rd_en_i |=> count_i == $past(count_i) + 1'b1)
    else $error("encoder write was not stored in the FIFO");

  bvalid_holds: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("s_bvalid_o dropped before bready");

  rvalid_holds: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("s_rvalid_o dropped before rready");

endmodule

bind dvs_readout_top dvs_readout_props u_props (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .aer_req_i (aer_req_i),
  .aer_ack_i (aer_ack_o),
  .wr_en_i   (wr_en),
  .rd_en_i   (rd_en),
  .count_i   (count),
  .bvalid_i  (s_bvalid_o),
  .bready_i  (s_bready_i),
  .rvalid_i  (s_rvalid_o),
  .rready_i  (s_rready_i)
);

//--- testbench/dvs_readout_tb.sv
/* Testbench for dvs_readout_top; events come from testbench/dvs_golden.txt relative to the
   project root. Exact CD words are only predicted under prescale 0xFFFF right after a clear. */
module dvs_readout_tb;

  localparam int N_EVENTS = 14;                     // Events in the golden file
  localparam int TMO      = 200;                    // Cycles allowed per wait
  localparam int POLL_MAX = 100;                    // STATUS polls per wait
  localparam int X_LSB    = dvs_pkg::COL_ADD;
  localparam int T_LSB    = dvs_pkg::COL_ADD + dvs_pkg::ROW_ADD;
  localparam int TYPE_LSB = dvs_pkg::WIDTH - 4;

  logic                        clk_i;
  logic                        reset_i;
  logic                        aer_req_i;
  logic [dvs_pkg::ROW_ADD-1:0] aer_x_i;
  logic [dvs_pkg::COL_ADD-1:0] aer_y_i;
  logic                        aer_pol_i;
  logic                        aer_ack_o;
  logic [3:0]                  s_awaddr_i;
  logic                        s_awvalid_i;
  logic                        s_awready_o;
  logic [dvs_pkg::WIDTH-1:0]   s_wdata_i;
  logic                        s_wvalid_i;
  logic                        s_wready_o;
  logic [1:0]                  s_bresp_o;
  logic                        s_bvalid_o;
  logic                        s_bready_i;
  logic [3:0]                  s_araddr_i;
  logic                        s_arvalid_i;
  logic                        s_arready_o;
  logic [dvs_pkg::WIDTH-1:0]   s_rdata_o;
  logic [1:0]                  s_rresp_o;
  logic                        s_rvalid_o;
  logic                        s_rready_i;

  logic [15:0]                     golden [4*N_EVENTS];  // x, y, pol, type per event
  logic [31:0]                     expect_q [$];          // Words still to be read back
  int                              seed = 32'h93366090;
  int                              errors = 0;
  int                              test_num = 0;
  int                              tests_failed = 0;
  int                              test_errs = 0;         // Error count when the test began
  bit                              have_high = 1'b0;
  logic [dvs_pkg::TIME_HIGH_W-1:0] last_high;
  logic [dvs_pkg::SIZE-1:0]        prev_ts = '0;

  dvs_readout_top uut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .aer_req_i   (aer_req_i),
    .aer_x_i     (aer_x_i),
    .aer_y_i     (aer_y_i),
    .aer_pol_i   (aer_pol_i),
    .aer_ack_o   (aer_ack_o),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;                      // Period 4
  end

  task automatic report_mismatch(input string sig, input logic [31:0] want,
                                 input logic [31:0] got);
    $display("FAILED at %0t: %s expected %h got %h", $time, sig, want, got);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic end_test(input string name);
    test_num++;
    if (errors == test_errs)
      $display("test %0d %s: pass", test_num, name);
    else
    begin
      $display("test %0d %s: fail", test_num, name);
      tests_failed++;
    end
    test_errs = errors;
  endtask

  // CD word with a zero low-time field, built from the golden row
  function automatic logic [31:0] cd_expect(input int idx);
    return {golden[4*idx+3][3:0], 6'd0, golden[4*idx][10:0], golden[4*idx+1][10:0]};
  endfunction

  task automatic aer_raise(input int idx);
    @(posedge clk_i);
    aer_x_i   <= golden[4*idx][10:0];
    aer_y_i   <= golden[4*idx+1][10:0];
    aer_pol_i <= golden[4*idx+2][0];
    aer_req_i <= 1'b1;
  endtask

  task automatic aer_drop();
    @(posedge clk_i);
    aer_req_i <= 1'b0;
  endtask

  task automatic wait_ack(input logic level, input string what);
    int n;
    n = 0;
    do
    begin
      @(negedge clk_i);
      n++;
    end
    while (aer_ack_o !== level && n < TMO);
    if (aer_ack_o !== level)
      report_problem({"timed out waiting for ack to ", what});
  endtask

  // Bounded watch that ack does not rise
  task automatic watch_ack_low(input int cycles, output bit held);
    held = 1'b1;
    for (int n = 0; n < cycles; n++)
    begin
      @(negedge clk_i);
      if (aer_ack_o)
        held = 1'b0;
    end
  endtask

  task automatic aer_send(input int idx);
    int gap;
    gap = $random(seed) & 7;                        // Idle cycles before the request
    repeat (gap) @(posedge clk_i);
    aer_raise(idx);
    wait_ack(1'b1, "rise");
    aer_drop();
    wait_ack(1'b0, "fall");
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    int n;
    @(posedge clk_i);
    s_awaddr_i  <= addr;
    s_awvalid_i <= 1'b1;
    s_wdata_i   <= data;
    s_wvalid_i  <= 1'b1;
    s_bready_i  <= 1'b1;
    n = 0;
    do
    begin
      @(negedge clk_i);
      n++;
    end
    while (!s_awready_o && n < TMO);
    if (!s_awready_o)
      report_problem("timed out waiting for awready");
    else if (s_wready_o !== 1'b1)
      report_mismatch("s_wready_o", 32'd1, 32'(s_wready_o));
    @(posedge clk_i);                               // Address and data accepted here
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    n = 0;
    do
    begin
      @(negedge clk_i);
      n++;
    end
    while (!s_bvalid_o && n < TMO);
    if (!s_bvalid_o)
      report_problem("timed out waiting for bvalid");
    else if (s_bresp_o !== dvs_pkg::RESP_OKAY)
      report_mismatch("s_bresp_o", 32'(dvs_pkg::RESP_OKAY), 32'(s_bresp_o));
    @(posedge clk_i);
    s_bready_i <= 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    @(posedge clk_i);
    s_araddr_i  <= addr;
    s_arvalid_i <= 1'b1;
    s_rready_i  <= 1'b1;
    n = 0;
    do
    begin
      @(negedge clk_i);
      n++;
    end
    while (!s_arready_o && n < TMO);
    if (!s_arready_o)
      report_problem("timed out waiting for arready");
    @(posedge clk_i);
    s_arvalid_i <= 1'b0;
    n = 0;
    do
    begin
      @(negedge clk_i);
      n++;
    end
    while (!s_rvalid_o && n < TMO);
    if (!s_rvalid_o)
      report_problem("timed out waiting for rvalid");
    data = s_rdata_o;                               // Stable at the falling edge
    resp = s_rresp_o;
    @(posedge clk_i);
    s_rready_i <= 1'b0;
  endtask

  // Polls STATUS until the count reaches want
  task automatic wait_count(input int want);
    logic [31:0] cnt;
    logic [1:0]  resp;
    int          polls;
    polls = 0;
    do
    begin
      axi_read(dvs_pkg::REG_STATUS, cnt, resp);
      polls++;
    end
    while (cnt != 32'(want) && polls < POLL_MAX);
    if (cnt != 32'(want))
      report_mismatch("STATUS count", 32'(want), cnt);
  endtask

  task automatic fetch_word(output logic [31:0] w);
    logic [31:0] cnt;
    logic [1:0]  resp;
    int          polls;
    polls = 0;
    w = '0;
    do
    begin
      axi_read(dvs_pkg::REG_STATUS, cnt, resp);
      polls++;
    end
    while (cnt == 0 && polls < POLL_MAX);
    if (cnt == 0)
      report_problem("no word arrived in the FIFO");
    else
    begin
      axi_read(dvs_pkg::REG_DATA, w, resp);
      if (resp !== dvs_pkg::RESP_OKAY)
        report_mismatch("s_rresp_o", 32'(dvs_pkg::RESP_OKAY), 32'(resp));
    end
  endtask

  // One event through the stream, checked against the word format rules
  task automatic process_event(input int idx, output bit high_first);
    logic [31:0]              w;
    logic [dvs_pkg::SIZE-1:0] ts;
    high_first = 1'b0;
    aer_send(idx);
    fetch_word(w);
    if (w[31:TYPE_LSB] == dvs_pkg::TYPE_TIME_HIGH)
    begin
      high_first = 1'b1;
      if (have_high && w[dvs_pkg::TIME_HIGH_W-1:0] == last_high)
        report_problem("TIME_HIGH word repeats the previous high field");
      last_high = w[dvs_pkg::TIME_HIGH_W-1:0];
      have_high = 1'b1;
      fetch_word(w);                                // CD word follows
    end
    if (!have_high)
      report_problem("CD word arrived before any TIME_HIGH word");
    if (w[31:TYPE_LSB] !== golden[4*idx+3][3:0])
      report_mismatch("CD type", 32'(golden[4*idx+3][3:0]), 32'(w[31:TYPE_LSB]));
    if (w[T_LSB-1:X_LSB] !== golden[4*idx][10:0])
      report_mismatch("CD x", 32'(golden[4*idx][10:0]), 32'(w[T_LSB-1:X_LSB]));
    if (w[X_LSB-1:0] !== golden[4*idx+1][10:0])
      report_mismatch("CD y", 32'(golden[4*idx+1][10:0]), 32'(w[X_LSB-1:0]));
    ts = {last_high, w[TYPE_LSB-1:T_LSB]};          // High field joined with the low field
    if (ts < prev_ts)
      report_problem("reconstructed timestamp decreased");
    prev_ts = ts;
  endtask

  initial
  begin
    logic [31:0] data;
    logic [31:0] want;
    logic [1:0]  resp;
    bit          held;
    bit          high_first;
    reset_i     = 1'b1;
    aer_req_i   = 1'b0;
    aer_x_i     = '0;
    aer_y_i     = '0;
    aer_pol_i   = 1'b0;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    $readmemh("testbench/dvs_golden.txt", golden);
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;

    axi_read(dvs_pkg::REG_STATUS, data, resp);
    if (data !== 32'd0)
      report_mismatch("STATUS count", 32'd0, data);
    aer_raise(0);
    watch_ack_low(24, held);
    if (!held)
      report_problem("ack rose while the readout was disabled");
    aer_drop();
    end_test("reset and disabled");

    axi_write(dvs_pkg::REG_CTRL, 32'h1);
    process_event(0, high_first);
    if (!high_first)
      report_problem("first event after enable had no TIME_HIGH word");
    end_test("first event after enable");

    for (int i = 1; i < N_EVENTS; i++)
      process_event(i, high_first);
    end_test("golden event stream");

    axi_write(dvs_pkg::REG_CTRL, 32'h0);            // Forget the last high field
    axi_write(dvs_pkg::REG_PRESCALE, 32'hFFFF);
    axi_write(dvs_pkg::REG_CTRL, 32'h3);            // Enable and clear together
    aer_send(1);
    fetch_word(data);
    if (data !== {dvs_pkg::TYPE_TIME_HIGH, 28'd0})
      report_mismatch("TIME_HIGH after clear", {dvs_pkg::TYPE_TIME_HIGH, 28'd0}, data);
    fetch_word(data);
    if (data !== cd_expect(1))
      report_mismatch("CD after clear", cd_expect(1), data);
    end_test("prescale and clear");

    for (int i = 0; i < 16; i++)
    begin
      aer_send(i % N_EVENTS);
      expect_q.push_back(cd_expect(i % N_EVENTS));
    end
    wait_count(16);
    aer_send(16 % N_EVENTS);                        // Held inside capture
    expect_q.push_back(cd_expect(16 % N_EVENTS));
    aer_raise(17 % N_EVENTS);
    expect_q.push_back(cd_expect(17 % N_EVENTS));
    watch_ack_low(24, held);
    if (!held)
      report_problem("ack was given while the FIFO and capture were full");
    axi_read(dvs_pkg::REG_DATA, data, resp);
    want = expect_q.pop_front();
    if (data !== want)
      report_mismatch("DATA word", want, data);
    wait_ack(1'b1, "rise after a DATA read");
    aer_drop();
    wait_ack(1'b0, "fall");
    while (expect_q.size() > 0)
    begin
      fetch_word(data);
      want = expect_q.pop_front();
      if (data !== want)
        report_mismatch("DATA word", want, data);
    end
    wait_count(0);                                  // Nothing extra left behind
    end_test("full FIFO back-pressure");

    axi_read(dvs_pkg::REG_DATA, data, resp);
    if (resp !== dvs_pkg::RESP_SLVERR)
      report_mismatch("s_rresp_o", 32'(dvs_pkg::RESP_SLVERR), 32'(resp));
    if (data !== 32'd0)
      report_mismatch("s_rdata_o", 32'd0, data);
    end_test("read from an empty FIFO");

    $display("%0d tests, %0d failed, %0d errors", test_num, tests_failed, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

//--- testbench/dvs_golden.txt
// Columns: x (row address), y (column address), polarity, expected CD type code, all hex
// Type is 1 for an ON event and 0 for an OFF event
000 000 1 1
7ff 7ff 0 0
123 456 1 1
2aa 155 0 0
001 7fe 1 1
400 200 1 1
0f0 00f 0 0
3c3 5a5 0 0
7fe 001 1 1
055 2aa 1 1
111 222 0 0
6db 249 1 1
080 700 0 0
35c 4a3 1 1

//--- build.f
common/dvs_pkg.sv
hdl/aer_capture.sv
hdl/timestamp_counter.sv
encoder/event_encoder.sv
hdl/event_fifo.sv
hdl/axi_lite_regs.sv
hdl/dvs_readout_top.sv
testbench/dvs_readout_props.sv
testbench/dvs_readout_tb.sv

//--- build.sh
#!/usr/bin/env bash
# Builds the DVS readout testbench with Verilator, runs it and checks the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module dvs_readout_tb -o dvs_readout_sim
./obj_dir/dvs_readout_sim | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
